// ==== rtl/dot_pkg.sv ====
package dot_pkg;

  // Number of vector lanes carried in one beat
  localparam int lanes = 8;

  // Lane operand width
  // Operands are signed Q1.15
  localparam int in_width = 16;

  // Fraction bits of the Q1.15 format
  localparam int frac_bits = 15;

  // Full product of two lanes
  // Q2.30 needs twice the operand width
  localparam int prod_width = 2 * in_width;

  // One adder tree level per halving of the lane count
  localparam int tree_levels = $clog2(lanes);

  // Each tree level keeps its carry bit
  localparam int sum_width = prod_width + tree_levels;

  // Result width after rounding back to Q1.15
  localparam int out_width = 16;

  // Cycles from input acceptance to out_valid with no stall
  // Multiply slice, one slice per tree level, then the result slice
  localparam int pipe_latency = 1 + tree_levels + 1;

endpackage

// ==== rtl/register_slice.sv ====
`timescale 1ns/1ns

module register_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  // Set while the slice holds a beat
  logic full;
  // Beat accepted from upstream this cycle
  logic load;

  // Accept when empty or when the held beat leaves this cycle
  assign in_ready = !full || out_ready;
  assign load = in_valid && in_ready;

  // Held beat is presented downstream as soon as it is stored
  assign out_valid = full;

  // Occupancy follows the upstream valid whenever the slot frees up
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (in_ready) begin
      full <= in_valid;
    end
  end

  // Payload only changes on an accepted beat
  // Data stays steady while the downstream side stalls
  always_ff @(posedge clk) begin
    if (load) begin
      out_data <= in_data;
    end
  end

endmodule

// ==== rtl/fixed_adder_tree_layer.sv ====
`timescale 1ns/1ns

module fixed_adder_tree_layer #(
  parameter int in_size  = 8,
  parameter int in_width = 32
) (
  input  logic [in_size*in_width-1:0]               data_in,
  output logic [((in_size+1)/2)*(in_width+1)-1:0]   data_out
);

  // Words produced by this level
  localparam int out_size = (in_size + 1) / 2;

  // One adder per adjacent pair of input words
  for (genvar i = 0; i < in_size / 2; i++) begin : g_pair
    logic signed [in_width-1:0] lhs;
    logic signed [in_width-1:0] rhs;

    assign lhs = data_in[(2*i)*in_width +: in_width];
    assign rhs = data_in[(2*i+1)*in_width +: in_width];

    // Sign extend both operands so the carry lands in the new MSB
    assign data_out[i*(in_width+1) +: in_width+1] =
      {lhs[in_width-1], lhs} + {rhs[in_width-1], rhs};
  end

  // Odd word count leaves one word without a partner
  if (in_size % 2 == 1) begin : g_odd
    logic signed [in_width-1:0] last;

    assign last = data_in[(in_size-1)*in_width +: in_width];

    // Passed through with one bit of sign extension
    assign data_out[(out_size-1)*(in_width+1) +: in_width+1] = {last[in_width-1], last};
  end

endmodule

// ==== rtl/fixed_adder_tree.sv ====
`timescale 1ns/1ns

module fixed_adder_tree (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic                                         in_valid,
  output logic                                         in_ready,
  input  logic [dot_pkg::lanes*dot_pkg::prod_width-1:0] in_data,
  output logic                                         out_valid,
  input  logic                                         out_ready,
  output logic [dot_pkg::sum_width-1:0]                out_data
);

  import dot_pkg::*;

  // Stream between levels
  // Stage 0 is the product input, the last stage is the final sum
  for (genvar i = 0; i <= tree_levels; i++) begin : g_stage
    // Word count at this stage is ceil(lanes / 2^i)
    localparam int stage_size = (lanes + ((1 << i) - 1)) >> i;
    // Words grow one bit per level to hold the carry
    localparam int stage_width = prod_width + i;

    logic [stage_size*stage_width-1:0] data;
    logic                              valid;
    logic                              ready;
  end

  // One adder layer and one register slice per level
  for (genvar i = 0; i < tree_levels; i++) begin : g_level
    localparam int lvl_size   = (lanes + ((1 << i) - 1)) >> i;
    localparam int lvl_width  = prod_width + i;
    localparam int next_size  = (lvl_size + 1) / 2;

    // Packed sums of this level form the slice payload
    typedef logic [next_size*(lvl_width+1)-1:0] level_t;

    level_t sum;

    fixed_adder_tree_layer #(
      .in_size  (lvl_size),
      .in_width (lvl_width)
    ) i_layer (
      .data_in  (g_stage[i].data),
      .data_out (sum)
    );

    // Register slice cuts the path after every adder layer
    register_slice #(
      .payload_t (level_t)
    ) i_slice (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (g_stage[i].valid),
      .in_ready  (g_stage[i].ready),
      .in_data   (sum),
      .out_valid (g_stage[i+1].valid),
      .out_ready (g_stage[i+1].ready),
      .out_data  (g_stage[i+1].data)
    );
  end

  // Product stream enters at stage 0
  assign g_stage[0].data  = in_data;
  assign g_stage[0].valid = in_valid;
  assign in_ready         = g_stage[0].ready;

  // Single word left after the last level is the full sum
  assign out_data                   = g_stage[tree_levels].data;
  assign out_valid                  = g_stage[tree_levels].valid;
  assign g_stage[tree_levels].ready = out_ready;

endmodule

// ==== rtl/lane_multiplier.sv ====
`timescale 1ns/1ns

module lane_multiplier (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic                                         in_valid,
  output logic                                         in_ready,
  input  logic [dot_pkg::lanes*dot_pkg::in_width-1:0]   vec_a,
  input  logic [dot_pkg::lanes*dot_pkg::in_width-1:0]   vec_b,
  output logic                                         out_valid,
  input  logic                                         out_ready,
  output logic [dot_pkg::lanes*dot_pkg::prod_width-1:0] out_data
);

  import dot_pkg::*;

  // All lane products packed lane 0 first
  typedef logic [lanes*prod_width-1:0] prod_vec_t;

  prod_vec_t products;

  // Unpack each lane and form its signed product
  for (genvar i = 0; i < lanes; i++) begin : g_lane
    logic signed [in_width-1:0]   a;
    logic signed [in_width-1:0]   b;
    logic signed [prod_width-1:0] p;

    assign a = vec_a[i*in_width +: in_width];
    assign b = vec_b[i*in_width +: in_width];

    // Q1.15 times Q1.15 gives Q2.30
    // Only -1 times -1 needs the top integer bit
    assign p = a * b;

    assign products[i*prod_width +: prod_width] = p;
  end

  // Products leave through one slice
  register_slice #(
    .payload_t (prod_vec_t)
  ) i_slice (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (products),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

endmodule

// ==== rtl/round_saturate.sv ====
`timescale 1ns/1ns

module round_saturate (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  in_valid,
  output logic                                  in_ready,
  input  logic signed [dot_pkg::sum_width-1:0]  in_data,
  output logic                                  out_valid,
  input  logic                                  out_ready,
  output logic signed [dot_pkg::out_width-1:0]  result
);

  import dot_pkg::*;

  typedef logic [out_width-1:0] result_t;

  // One guard bit so the rounding add cannot wrap
  logic signed [sum_width:0] biased;
  logic signed [sum_width:0] shifted;
  // High when the shifted value does not fit in out_width bits
  logic                      overflow;
  result_t                   clamped;

  // Add half of one Q1.15 LSB in Q(n).30 terms
  // Bias then floor gives round half up
  assign biased  = {in_data[sum_width-1], in_data}
                   + ((sum_width + 1)'(1) << (frac_bits - 1));
  assign shifted = biased >>> frac_bits;

  // Fits only if every bit above the result MSB copies the sign
  assign overflow = !((&shifted[sum_width:out_width-1]) || !(|shifted[sum_width:out_width-1]));

  // Clamp toward the sign of the true value
  always_comb begin
    if (!overflow) begin
      clamped = shifted[out_width-1:0];
    end else if (shifted[sum_width]) begin
      clamped = {1'b1, {(out_width-1){1'b0}}};
    end else begin
      clamped = {1'b0, {(out_width-1){1'b1}}};
    end
  end

  // Result leaves through one slice
  register_slice #(
    .payload_t (result_t)
  ) i_slice (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (clamped),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (result)
  );

endmodule

// ==== rtl/fixed_dot_product.sv ====
`timescale 1ns/1ns

module fixed_dot_product (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        in_valid,
  output logic                                        in_ready,
  input  logic [dot_pkg::lanes*dot_pkg::in_width-1:0]  vec_a,
  input  logic [dot_pkg::lanes*dot_pkg::in_width-1:0]  vec_b,
  output logic                                        out_valid,
  input  logic                                        out_ready,
  output logic signed [dot_pkg::out_width-1:0]        result
);

  import dot_pkg::*;

  // Lane products from the multiply stage
  logic                         prod_valid;
  logic                         prod_ready;
  logic [lanes*prod_width-1:0]  prod_data;

  // Full-precision sum from the adder tree
  logic                         sum_valid;
  logic                         sum_ready;
  logic [sum_width-1:0]         sum_data;

  // Unpack operands and multiply lane by lane
  lane_multiplier i_mult (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .vec_a     (vec_a),
    .vec_b     (vec_b),
    .out_valid (prod_valid),
    .out_ready (prod_ready),
    .out_data  (prod_data)
  );

  // Reduce the products over tree_levels registered levels
  fixed_adder_tree i_tree (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (prod_valid),
    .in_ready  (prod_ready),
    .in_data   (prod_data),
    .out_valid (sum_valid),
    .out_ready (sum_ready),
    .out_data  (sum_data)
  );

  // Back to Q1.15 with rounding and saturation
  round_saturate i_round (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (sum_valid),
    .in_ready  (sum_ready),
    .in_data   (sum_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .result    (result)
  );

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int period_ns    = 20,
  parameter int reset_cycles = 4
) (
  output logic clk,
  output logic rst_n
);

  // Free running clock
  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // Reset held over reset_cycles rising edges, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// ==== dv/fixed_dot_product_asserts.sv ====
`timescale 1ns/1ns

module fixed_dot_product_asserts (
  input logic                                 clk,
  input logic                                 rst_n,
  input logic                                 in_ready,
  input logic                                 out_valid,
  input logic                                 out_ready,
  input logic signed [dot_pkg::out_width-1:0] result
);

  // A stalled output beat keeps its valid and its value
  property stall_holds_beat;
    @(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid && $stable(result);
  endproperty

  // Handshake outputs are always driven once out of reset
  property handshake_known;
    @(posedge clk) disable iff (!rst_n)
      !$isunknown({in_ready, out_valid});
  endproperty

  // Every slice starts empty
  property idle_after_reset;
    @(posedge clk) $rose(rst_n) |-> !out_valid;
  endproperty

  assert property (stall_holds_beat)
    else $error("output beat changed while stalled");
  assert property (handshake_known)
    else $error("in_ready or out_valid unknown after reset");
  assert property (idle_after_reset)
    else $error("out_valid high in first cycle after reset");

endmodule

bind fixed_dot_product fixed_dot_product_asserts i_asserts (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .result    (result)
);

// ==== dv/tb_fixed_dot_product.sv ====
`timescale 1ns/1ns

module tb_fixed_dot_product;

  import dot_pkg::*;

  // Cycles from input transfer to output transfer with no stall
  localparam int expected_latency = 5;
  localparam int total_beats = 200 + 2 + 4 + 300;
  // Budget of 40 cycles of 20 ns per beat plus a margin
  localparam longint timeout_ns = longint'(total_beats) * 40 * 20 + 20000;

  logic clk;
  logic rst_n;
  logic in_valid;
  logic in_ready;
  logic [lanes*in_width-1:0] vec_a;
  logic [lanes*in_width-1:0] vec_b;
  logic out_valid;
  logic out_ready;
  logic signed [out_width-1:0] result;

  // Scoreboard state, owned by the monitor
  logic signed [out_width-1:0] expected_q[$];
  int in_cycle_q[$];
  int cycle;
  int in_count;
  int out_count;
  int mon_errors;

  // Test control, owned by the main process
  logic [15:0] lfsr;
  logic stall_mode;
  logic latency_check;
  int main_errors;
  int err_base;
  int in_base;
  int out_base;
  int tests_run;
  int tests_failed;

  tb_clock_gen #(.period_ns(20), .reset_cycles(4)) i_clk_gen (.clk(clk), .rst_n(rst_n));

  fixed_dot_product i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .vec_a     (vec_a),
    .vec_b     (vec_b),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .result    (result)
  );

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  // Reference: exact sum of products, round half up, clamp to Q1.15
  function automatic logic signed [out_width-1:0] dot_model(
    input logic [lanes*in_width-1:0] a,
    input logic [lanes*in_width-1:0] b
  );
    longint acc;
    longint rounded;
    logic signed [in_width-1:0] la;
    logic signed [in_width-1:0] lb;
    acc = 0;
    for (int i = 0; i < lanes; i++) begin
      la = a[i*in_width +: in_width];
      lb = b[i*in_width +: in_width];
      acc = acc + longint'(la) * longint'(lb);
    end
    rounded = (acc + 64'sd16384) >>> 15;
    if (rounded > 64'sd32767) return 16'sh7fff;
    if (rounded < -64'sd32768) return 16'sh8000;
    return rounded[15:0];
  endfunction

  // Compare one output transfer with the oldest expected beat
  task automatic check_output();
    logic signed [out_width-1:0] exp;
    int start;
    if (expected_q.size() == 0) begin
      $display("Output at %0t arrived with no accepted beat waiting for it", $time);
      mon_errors++;
    end else begin
      exp = expected_q.pop_front();
      start = in_cycle_q.pop_front();
      assert (result === exp) else begin
        $display("CHECK FAILED at %0t: result %0d, expected %0d", $time, result, exp);
        mon_errors++;
      end
      if (latency_check) begin
        assert (cycle - start == expected_latency) else begin
          $display("CHECK FAILED at %0t: latency %0d cycles, expected %0d",
                   $time, cycle - start, expected_latency);
          mon_errors++;
        end
      end
      out_count++;
    end
  endtask

  // Monitor samples both handshakes on the rising edge
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (rst_n && out_valid && out_ready) check_output();
    if (rst_n && in_valid && in_ready) begin
      expected_q.push_back(dot_model(vec_a, vec_b));
      in_cycle_q.push_back(cycle);
      in_count++;
    end
  end

  // 75 percent ready while stalling, otherwise always ready
  task automatic update_ready();
    out_ready = stall_mode ? (random_bits(2) != 0) : 1'b1;
  endtask

  // Idle gap, then hold the beat until it is taken
  task automatic send_beat(input logic [lanes*in_width-1:0] a,
                           input logic [lanes*in_width-1:0] b, input int gap);
    repeat (gap) begin
      @(negedge clk);
      in_valid = 1'b0;
      update_ready();
    end
    @(negedge clk);
    in_valid = 1'b1;
    vec_a = a;
    vec_b = b;
    update_ready();
    @(posedge clk);
    while (!in_ready) begin
      @(negedge clk);
      update_ready();
      @(posedge clk);
    end
  endtask

  task automatic random_vectors(output logic [lanes*in_width-1:0] a,
                                output logic [lanes*in_width-1:0] b);
    logic [31:0] v;
    for (int i = 0; i < lanes; i++) begin
      v = random_bits(16);
      a[i*in_width +: in_width] = v[15:0];
      v = random_bits(16);
      b[i*in_width +: in_width] = v[15:0];
    end
  endtask

  // Wait until every accepted beat has come out, then catch strays
  task automatic wait_drain();
    @(negedge clk);
    in_valid = 1'b0;
    update_ready();
    while (expected_q.size() != 0) begin
      @(negedge clk);
      update_ready();
    end
    out_ready = 1'b1;
    repeat (expected_latency + 2) @(negedge clk);
  endtask

  task automatic start_test();
    err_base = mon_errors + main_errors;
    in_base = in_count;
    out_base = out_count;
  endtask

  task automatic finish_test(input string name, input int beats);
    int errs;
    int n_in;
    int n_out;
    n_in = in_count - in_base;
    n_out = out_count - out_base;
    assert (n_in == beats && n_out == n_in) else begin
      $display("CHECK FAILED at %0t: %s accepted %0d and returned %0d of %0d beats",
               $time, name, n_in, n_out, beats);
      main_errors++;
    end
    errs = mon_errors + main_errors - err_base;
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("test %s: %s, %0d beats, %0d errors", name, (errs == 0) ? "ok" : "FAIL", n_out, errs);
  endtask

  // Ends a run that hangs
  initial begin
    #(timeout_ns);
    $display("Watchdog expired after %0d ns before the run finished", timeout_ns);
    $display("tests failed");
    $finish;
  end

  initial begin
    logic [lanes*in_width-1:0] a;
    logic [lanes*in_width-1:0] b;
    in_valid = 1'b0;
    out_ready = 1'b1;
    vec_a = '0;
    vec_b = '0;
    lfsr = 16'd34174;
    stall_mode = 1'b0;
    latency_check = 1'b0;
    cycle = 0;
    in_count = 0;
    out_count = 0;
    mon_errors = 0;
    main_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    @(posedge rst_n);

    // Pipeline stays empty with nothing sent
    start_test();
    repeat (8) begin
      @(posedge clk);
      assert (out_valid === 1'b0) else begin
        $display("CHECK FAILED at %0t: out_valid high before any beat", $time);
        main_errors++;
      end
    end
    finish_test("reset_idle", 0);

    // Full throughput with fixed latency
    start_test();
    latency_check = 1'b1;
    repeat (200) begin
      random_vectors(a, b);
      send_beat(a, b, 0);
    end
    wait_drain();
    latency_check = 1'b0;
    finish_test("random_stream", 200);

    // Both saturation limits
    start_test();
    send_beat({lanes{16'sh8000}}, {lanes{16'sh8000}}, 0);
    send_beat({lanes{16'sh7fff}}, {lanes{16'sh8000}}, 0);
    wait_drain();
    finish_test("saturation", 2);

    // Sums exactly on half an output LSB
    start_test();
    send_beat({{(lanes-1)*in_width{1'b0}}, 16'sd1}, {{(lanes-1)*in_width{1'b0}}, 16'sd16384}, 0);
    send_beat({{(lanes-1)*in_width{1'b0}}, -16'sd1}, {{(lanes-1)*in_width{1'b0}}, 16'sd16384}, 0);
    send_beat({{(lanes-1)*in_width{1'b0}}, 16'sd3}, {{(lanes-1)*in_width{1'b0}}, 16'sd16384}, 0);
    send_beat({{(lanes-1)*in_width{1'b0}}, -16'sd3}, {{(lanes-1)*in_width{1'b0}}, 16'sd16384}, 0);
    wait_drain();
    finish_test("rounding", 4);

    // Random gaps upstream and stalls downstream
    start_test();
    stall_mode = 1'b1;
    repeat (300) begin
      random_vectors(a, b);
      send_beat(a, b, random_bits(1) != 0 ? int'(random_bits(2)) : 0);
    end
    wait_drain();
    stall_mode = 1'b0;
    finish_test("backpressure", 300);

    $display("summary: %0d run, %0d failing, %0d check errors",
             tests_run, tests_failed, mon_errors + main_errors);
    if (tests_failed == 0 && mon_errors + main_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
rtl/dot_pkg.sv
rtl/register_slice.sv
rtl/fixed_adder_tree_layer.sv
rtl/fixed_adder_tree.sv
rtl/lane_multiplier.sv
rtl/round_saturate.sv
rtl/fixed_dot_product.sv
dv/tb_clock_gen.sv
dv/fixed_dot_product_asserts.sv
dv/tb_fixed_dot_product.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the dot-product testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 -f files.f \
  --top-module tb_fixed_dot_product -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "simulation did not complete"; exit 1; }
cat sim.log
grep -qx "all tests passed" sim.log && exit 0 || exit 1
